//--- Makefile
LOG := sim.log

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module csrTb -f sim.f \
		-Mdir obj_dir -o Vsim

run: build
	./obj_dir/Vsim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/csrPkg.sv
`default_nettype none

package csrPkg;

    // ------------------------------
    // Widths and basic types
    // ------------------------------
    typedef logic [31:0] word_t;
    typedef logic [11:0] csrAddr_t;
    typedef logic [3:0]  causeCode_t;
    typedef logic [63:0] cycleCount_t;

    typedef enum logic [1:0] {
        PrivUser       = 2'b00,
        PrivSupervisor = 2'b01,
        PrivMachine    = 2'b11
    } privilege_e;

    // RV32 mstatus, msb first
    typedef struct packed {
        logic       sd;
        logic [7:0] wpri3;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] wpri2;
        logic       spp;
        logic       mpie;
        logic       wpri1;
        logic       spie;
        logic       upie;
        logic       mie;
        logic       wpri0;
        logic       sie;
        logic       uie;
    } csrStatus_t;

    typedef struct packed {
        logic       valid;
        causeCode_t cause;
        word_t      pc;
        word_t      value;
    } trapRequest_t;

    typedef struct packed {
        logic     enable;
        csrAddr_t addr;
        word_t    data;
    } csrWrite_t;

    typedef struct packed {
        word_t mtvec;
        word_t stvec;
        word_t medeleg;
    } trapSetup_t;

    // Saved state of one trap level
    typedef struct packed {
        word_t      epc;
        causeCode_t cause;
        word_t      tval;
    } trapRecord_t;

    // ------------------------------
    // CSR addresses
    // ------------------------------
    localparam csrAddr_t CSR_ADDR_SSTATUS   = 12'h100;
    localparam csrAddr_t CSR_ADDR_STVEC     = 12'h105;
    localparam csrAddr_t CSR_ADDR_SSCRATCH  = 12'h140;
    localparam csrAddr_t CSR_ADDR_SEPC      = 12'h141;
    localparam csrAddr_t CSR_ADDR_SCAUSE    = 12'h142;
    localparam csrAddr_t CSR_ADDR_STVAL     = 12'h143;

    localparam csrAddr_t CSR_ADDR_MSTATUS   = 12'h300;
    localparam csrAddr_t CSR_ADDR_MISA      = 12'h301;
    localparam csrAddr_t CSR_ADDR_MEDELEG   = 12'h302;
    localparam csrAddr_t CSR_ADDR_MTVEC     = 12'h305;
    localparam csrAddr_t CSR_ADDR_MSCRATCH  = 12'h340;
    localparam csrAddr_t CSR_ADDR_MEPC      = 12'h341;
    localparam csrAddr_t CSR_ADDR_MCAUSE    = 12'h342;
    localparam csrAddr_t CSR_ADDR_MTVAL     = 12'h343;

    localparam csrAddr_t CSR_ADDR_CYCLE     = 12'hc00;
    localparam csrAddr_t CSR_ADDR_TIME      = 12'hc01;
    localparam csrAddr_t CSR_ADDR_CYCLEH    = 12'hc80;
    localparam csrAddr_t CSR_ADDR_TIMEH     = 12'hc81;

    localparam csrAddr_t CSR_ADDR_MVENDORID = 12'hf11;
    localparam csrAddr_t CSR_ADDR_MARCHID   = 12'hf12;
    localparam csrAddr_t CSR_ADDR_MIMPID    = 12'hf13;
    localparam csrAddr_t CSR_ADDR_MHARTID   = 12'hf14;

    // Machine information, RV32I only
    localparam word_t MISA_VALUE      = 32'h4000_0100;
    localparam word_t MVENDORID_VALUE = 32'h0;
    localparam word_t MARCHID_VALUE   = 32'h0;
    localparam word_t MIMPID_VALUE    = 32'h0;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic csrStatus_t sstatusMask();
        csrStatus_t mask;
        mask = '0;
        mask.sd   = 1'b1;
        mask.mxr  = 1'b1;
        mask.sum  = 1'b1;
        mask.xs   = 2'b11;
        mask.fs   = 2'b11;
        mask.spp  = 1'b1;
        mask.spie = 1'b1;
        mask.upie = 1'b1;
        mask.sie  = 1'b1;
        mask.uie  = 1'b1;
        return mask;
    endfunction

    localparam csrStatus_t SSTATUS_MASK = sstatusMask();

    // Fields outside the sstatus view keep their value
    function automatic csrStatus_t writeSstatus(csrStatus_t current, word_t data);
        return csrStatus_t'((current & ~SSTATUS_MASK) | (data & SSTATUS_MASK));
    endfunction

    function automatic logic csrWriteHit(csrWrite_t wr, csrAddr_t addr);
        return wr.enable && (wr.addr == addr);
    endfunction

    // Interrupt bit 31 stays zero
    function automatic word_t readCause(causeCode_t cause);
        return {28'h0, cause};
    endfunction

endpackage

`default_nettype wire

//--- rtl/csrRegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module csrRegisterFile
    import csrPkg::*;
#(
    parameter word_t HART_ID = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  csrWrite_t   csrWr,
    input  csrAddr_t    readAddr,
    input  csrStatus_t  status,
    input  trapRecord_t machineRec,
    input  trapRecord_t supervisorRec,
    output trapSetup_t  setup,
    output word_t       readValue
);

    word_t       mscratch;
    word_t       sscratch;
    cycleCount_t cycleCount;

    // ------------------------------
    // Software written registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            setup      <= '0;
            mscratch   <= '0;
            sscratch   <= '0;
            cycleCount <= '0;
        end else begin
            // Free running, also serves as time
            cycleCount <= cycleCount + 64'd1;

            if (csrWriteHit(csrWr, CSR_ADDR_MTVEC)) begin
                setup.mtvec <= csrWr.data;
            end
            if (csrWriteHit(csrWr, CSR_ADDR_STVEC)) begin
                setup.stvec <= csrWr.data;
            end
            if (csrWriteHit(csrWr, CSR_ADDR_MEDELEG)) begin
                setup.medeleg <= csrWr.data;
            end
            if (csrWriteHit(csrWr, CSR_ADDR_MSCRATCH)) begin
                mscratch <= csrWr.data;
            end
            if (csrWriteHit(csrWr, CSR_ADDR_SSCRATCH)) begin
                sscratch <= csrWr.data;
            end
        end
    end

    // ------------------------------
    // Read decode
    // ------------------------------
    always_comb begin
        case (readAddr)
            CSR_ADDR_SSTATUS:   readValue = status & SSTATUS_MASK;
            CSR_ADDR_STVEC:     readValue = setup.stvec;
            CSR_ADDR_SSCRATCH:  readValue = sscratch;
            CSR_ADDR_SEPC:      readValue = supervisorRec.epc;
            CSR_ADDR_SCAUSE:    readValue = readCause(supervisorRec.cause);
            CSR_ADDR_STVAL:     readValue = supervisorRec.tval;

            CSR_ADDR_MSTATUS:   readValue = status;
            CSR_ADDR_MISA:      readValue = MISA_VALUE;
            CSR_ADDR_MEDELEG:   readValue = setup.medeleg;
            CSR_ADDR_MTVEC:     readValue = setup.mtvec;
            CSR_ADDR_MSCRATCH:  readValue = mscratch;
            CSR_ADDR_MEPC:      readValue = machineRec.epc;
            CSR_ADDR_MCAUSE:    readValue = readCause(machineRec.cause);
            CSR_ADDR_MTVAL:     readValue = machineRec.tval;

            CSR_ADDR_CYCLE:     readValue = cycleCount[31:0];
            CSR_ADDR_TIME:      readValue = cycleCount[31:0];
            CSR_ADDR_CYCLEH:    readValue = cycleCount[63:32];
            CSR_ADDR_TIMEH:     readValue = cycleCount[63:32];

            CSR_ADDR_MVENDORID: readValue = MVENDORID_VALUE;
            CSR_ADDR_MARCHID:   readValue = MARCHID_VALUE;
            CSR_ADDR_MIMPID:    readValue = MIMPID_VALUE;
            CSR_ADDR_MHARTID:   readValue = HART_ID;

            // Unimplemented addresses read as zero
            default:            readValue = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/csrTop.sv
`timescale 1ns/1ps
`default_nettype none

module csrTop
    import csrPkg::*;
#(
    parameter word_t HART_ID = '0
) (
    input  logic         clk,
    input  logic         rst,
    input  trapRequest_t trap,
    input  logic         trapReturn,
    input  privilege_e   returnPrivilege,
    input  csrWrite_t    csrWr,
    input  csrAddr_t     readAddr,
    output word_t        readValue,
    output word_t        nextPc,
    output privilege_e   privilege,
    output csrStatus_t   status
);

    privilege_e  targetPriv;
    trapSetup_t  setup;
    trapRecord_t machineRec;
    trapRecord_t supervisorRec;

    // Privilege, status and next pc
    trapControl u_trapControl (
        .clk             (clk),
        .rst             (rst),
        .trap            (trap),
        .trapReturn      (trapReturn),
        .returnPrivilege (returnPrivilege),
        .csrWr           (csrWr),
        .setup           (setup),
        .machineRec      (machineRec),
        .supervisorRec   (supervisorRec),
        .targetPriv      (targetPriv),
        .privilege       (privilege),
        .status          (status),
        .nextPc          (nextPc)
    );

    // epc, cause and tval per level
    trapRecords u_trapRecords (
        .clk           (clk),
        .rst           (rst),
        .trap          (trap),
        .targetPriv    (targetPriv),
        .csrWr         (csrWr),
        .machineRec    (machineRec),
        .supervisorRec (supervisorRec)
    );

    csrRegisterFile #(
        .HART_ID (HART_ID)
    ) u_csrRegisterFile (
        .clk           (clk),
        .rst           (rst),
        .csrWr         (csrWr),
        .readAddr      (readAddr),
        .status        (status),
        .machineRec    (machineRec),
        .supervisorRec (supervisorRec),
        .setup         (setup),
        .readValue     (readValue)
    );

endmodule

`default_nettype wire

//--- rtl/trapControl.sv
`timescale 1ns/1ps
`default_nettype none

module trapControl
    import csrPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  trapRequest_t trap,
    input  logic         trapReturn,
    input  privilege_e   returnPrivilege,
    input  csrWrite_t    csrWr,
    input  trapSetup_t   setup,
    input  trapRecord_t  machineRec,
    input  trapRecord_t  supervisorRec,
    output privilege_e   targetPriv,
    output privilege_e   privilege,
    output csrStatus_t   status,
    output word_t        nextPc
);

    logic       delegated;
    logic       toMachine;
    logic       toSupervisor;
    logic       fromMachine;
    logic       fromSupervisor;
    csrStatus_t nextStatus;

    // mpp may hold the reserved encoding after a raw mstatus write
    function automatic privilege_e legalPrivilege(logic [1:0] encoded);
        return (encoded == 2'b10) ? PrivUser : privilege_e'(encoded);
    endfunction

    // ------------------------------
    // Event decode
    // ------------------------------
    assign delegated    = setup.medeleg[trap.cause];
    assign toMachine    = trap.valid && !delegated;
    assign toSupervisor = trap.valid && delegated;

    // A trap in the same cycle overrides the return
    assign fromMachine    = !trap.valid && trapReturn && (returnPrivilege == PrivMachine);
    assign fromSupervisor = !trap.valid && trapReturn && (returnPrivilege == PrivSupervisor);

    always_comb begin
        if (toMachine) begin
            targetPriv = PrivMachine;
        end else if (toSupervisor) begin
            targetPriv = PrivSupervisor;
        end else if (fromMachine) begin
            targetPriv = legalPrivilege(status.mpp);
        end else if (fromSupervisor) begin
            targetPriv = privilege_e'({1'b0, status.spp});
        end else begin
            targetPriv = privilege;
        end
    end

    // ------------------------------
    // Status update
    // ------------------------------
    always_comb begin
        nextStatus = status;
        if (toMachine) begin
            nextStatus.mpp = privilege;
        end else if (toSupervisor) begin
            nextStatus.spp = privilege[0];
        end else if (fromMachine) begin
            nextStatus.mie = status.mpie;
            nextStatus.mpp = PrivUser;
        end else if (fromSupervisor) begin
            nextStatus.sie = status.spie;
            nextStatus.spp = 1'b0;
        end else if (csrWriteHit(csrWr, CSR_ADDR_MSTATUS)) begin
            nextStatus = csrStatus_t'(csrWr.data);
        end else if (csrWriteHit(csrWr, CSR_ADDR_SSTATUS)) begin
            nextStatus = writeSstatus(status, csrWr.data);
        end
    end

    // Vector base is word aligned, mode bits dropped
    always_comb begin
        if (toMachine) begin
            nextPc = {setup.mtvec[31:2], 2'b00};
        end else if (toSupervisor) begin
            nextPc = {setup.stvec[31:2], 2'b00};
        end else if (fromMachine) begin
            nextPc = machineRec.epc;
        end else if (fromSupervisor) begin
            nextPc = supervisorRec.epc;
        end else begin
            nextPc = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= PrivMachine;
            status    <= '0;
        end else begin
            privilege <= targetPriv;
            status    <= nextStatus;
        end
    end

endmodule

`default_nettype wire

//--- rtl/trapRecords.sv
`timescale 1ns/1ps
`default_nettype none

module trapRecords
    import csrPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  trapRequest_t trap,
    input  privilege_e   targetPriv,
    input  csrWrite_t    csrWr,
    output trapRecord_t  machineRec,
    output trapRecord_t  supervisorRec
);

    logic toMachine;
    logic toSupervisor;

    // Same update rule for both levels, only the addresses differ
    function automatic trapRecord_t updateRecord(
        trapRecord_t  current,
        logic         trapHit,
        trapRequest_t req,
        csrWrite_t    wr,
        csrAddr_t     epcAddr,
        csrAddr_t     causeAddr,
        csrAddr_t     tvalAddr
    );
        trapRecord_t next;
        next = current;
        if (trapHit) begin
            next.epc   = req.pc;
            next.cause = req.cause;
            next.tval  = req.value;
        end else begin
            if (csrWriteHit(wr, epcAddr)) begin
                next.epc = wr.data;
            end
            // Only the exception code is stored
            if (csrWriteHit(wr, causeAddr)) begin
                next.cause = wr.data[3:0];
            end
            if (csrWriteHit(wr, tvalAddr)) begin
                next.tval = wr.data;
            end
        end
        return next;
    endfunction

    assign toMachine    = trap.valid && (targetPriv == PrivMachine);
    assign toSupervisor = trap.valid && (targetPriv == PrivSupervisor);

    always_ff @(posedge clk) begin
        if (rst) begin
            machineRec    <= '0;
            supervisorRec <= '0;
        end else begin
            machineRec <= updateRecord(machineRec, toMachine, trap, csrWr,
                                       CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL);
            supervisorRec <= updateRecord(supervisorRec, toSupervisor, trap, csrWr,
                                          CSR_ADDR_SEPC, CSR_ADDR_SCAUSE, CSR_ADDR_STVAL);
        end
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/csrPkg.sv
rtl/trapControl.sv
rtl/trapRecords.sv
rtl/csrRegisterFile.sv
rtl/csrTop.sv
verification/tbClock.sv
verification/csrTop_sva.sv
verification/csrTb.sv

//--- verification/csrTb.sv
`timescale 1ns/1ps
`default_nettype none

module csrTb
    import csrPkg::*;
();

    localparam int    RUN_CYCLES     = 2000;
    localparam int    TIMEOUT_CYCLES = RUN_CYCLES + 50;
    localparam word_t HART           = 32'h0;
    // sd, mxr, sum, xs, fs, spp, spie, upie, sie, uie
    localparam word_t SSTATUS_BITS   = 32'h800D_E133;
    localparam word_t MISA_RV32I     = 32'h4000_0100;

    logic         clk;
    logic         rst;
    trapRequest_t trap;
    logic         trapReturn;
    privilege_e   returnPrivilege;
    csrWrite_t    csrWr;
    csrAddr_t     readAddr;
    word_t        readValue;
    word_t        nextPc;
    privilege_e   privilege;
    csrStatus_t   status;

    word_t        rngState;
    int           errorCount;
    int           checkCount;
    int           resetWait;

    // Reference model state
    logic [1:0]   modelPriv;
    word_t        modelStatus;
    word_t        modelMtvec;
    word_t        modelStvec;
    word_t        modelMedeleg;
    word_t        modelMscratch;
    word_t        modelSscratch;
    word_t        modelMepc;
    word_t        modelMtval;
    word_t        modelSepc;
    word_t        modelStval;
    causeCode_t   modelMcause;
    causeCode_t   modelScause;
    cycleCount_t  modelCycles;

    tbClock u_clock (
        .clk (clk),
        .rst (rst)
    );

    csrTop #(
        .HART_ID (HART)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .trap            (trap),
        .trapReturn      (trapReturn),
        .returnPrivilege (returnPrivilege),
        .csrWr           (csrWr),
        .readAddr        (readAddr),
        .readValue       (readValue),
        .nextPc          (nextPc),
        .privilege       (privilege),
        .status          (status)
    );

    // ------------------------------
    // Random numbers
    // ------------------------------
    function automatic word_t xorshift32(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t randomWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Read-write registers
    function automatic csrAddr_t writeAddrFor(logic [3:0] sel);
        case (sel)
            4'd0:    return CSR_ADDR_SSTATUS;
            4'd1:    return CSR_ADDR_STVEC;
            4'd2:    return CSR_ADDR_SSCRATCH;
            4'd3:    return CSR_ADDR_SEPC;
            4'd4:    return CSR_ADDR_SCAUSE;
            4'd5:    return CSR_ADDR_STVAL;
            4'd6:    return CSR_ADDR_MSTATUS;
            4'd7:    return CSR_ADDR_MEDELEG;
            4'd8:    return CSR_ADDR_MTVEC;
            4'd9:    return CSR_ADDR_MSCRATCH;
            4'd10:   return CSR_ADDR_MEPC;
            4'd11:   return CSR_ADDR_MCAUSE;
            default: return CSR_ADDR_MTVAL;
        endcase
    endfunction

    // Read-write set, then read-only set, then anything
    function automatic csrAddr_t readAddrFor(logic [4:0] sel, csrAddr_t other);
        if (sel < 5'd13) begin
            return writeAddrFor(sel[3:0]);
        end
        case (sel)
            5'd13:   return CSR_ADDR_MISA;
            5'd14:   return CSR_ADDR_CYCLE;
            5'd15:   return CSR_ADDR_TIME;
            5'd16:   return CSR_ADDR_CYCLEH;
            5'd17:   return CSR_ADDR_TIMEH;
            5'd18:   return CSR_ADDR_MVENDORID;
            5'd19:   return CSR_ADDR_MARCHID;
            5'd20:   return CSR_ADDR_MIMPID;
            5'd21:   return CSR_ADDR_MHARTID;
            default: return other;
        endcase
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic resetModel();
        modelPriv     = 2'b11;
        modelStatus   = '0;
        modelMtvec    = '0;
        modelStvec    = '0;
        modelMedeleg  = '0;
        modelMscratch = '0;
        modelSscratch = '0;
        modelMepc     = '0;
        modelMtval    = '0;
        modelSepc     = '0;
        modelStval    = '0;
        modelMcause   = '0;
        modelScause   = '0;
        modelCycles   = '0;
    endtask

    task automatic writeModel(csrAddr_t addr, word_t data);
        case (addr)
            CSR_ADDR_SSTATUS:  modelStatus = (modelStatus & ~SSTATUS_BITS) | (data & SSTATUS_BITS);
            CSR_ADDR_STVEC:    modelStvec = data;
            CSR_ADDR_SSCRATCH: modelSscratch = data;
            CSR_ADDR_SEPC:     modelSepc = data;
            CSR_ADDR_SCAUSE:   modelScause = data[3:0];
            CSR_ADDR_STVAL:    modelStval = data;
            CSR_ADDR_MSTATUS:  modelStatus = data;
            CSR_ADDR_MEDELEG:  modelMedeleg = data;
            CSR_ADDR_MTVEC:    modelMtvec = data;
            CSR_ADDR_MSCRATCH: modelMscratch = data;
            CSR_ADDR_MEPC:     modelMepc = data;
            CSR_ADDR_MCAUSE:   modelMcause = data[3:0];
            CSR_ADDR_MTVAL:    modelMtval = data;
            default:           ;
        endcase
    endtask

    // Applies the inputs of the cycle that just ended
    task automatic updateModel();
        modelCycles = modelCycles + 64'd1;
        if (trap.valid) begin
            if (modelMedeleg[trap.cause]) begin
                modelSepc      = trap.pc;
                modelScause    = trap.cause;
                modelStval     = trap.value;
                modelStatus[8] = modelPriv[0];
                modelPriv      = 2'b01;
            end else begin
                modelMepc          = trap.pc;
                modelMcause        = trap.cause;
                modelMtval         = trap.value;
                modelStatus[12:11] = modelPriv;
                modelPriv          = 2'b11;
            end
        end else if (trapReturn && returnPrivilege == PrivMachine) begin
            // mret takes mie from mpie and sends mpp back to user
            modelPriv          = modelStatus[12:11];
            modelStatus[3]     = modelStatus[7];
            modelStatus[12:11] = 2'b00;
        end else if (trapReturn && returnPrivilege == PrivSupervisor) begin
            modelPriv      = {1'b0, modelStatus[8]};
            modelStatus[1] = modelStatus[5];
            modelStatus[8] = 1'b0;
        end else if (csrWr.enable) begin
            writeModel(csrWr.addr, csrWr.data);
        end
    endtask

    function automatic word_t expectedRead(csrAddr_t addr);
        case (addr)
            CSR_ADDR_SSTATUS:   return modelStatus & SSTATUS_BITS;
            CSR_ADDR_STVEC:     return modelStvec;
            CSR_ADDR_SSCRATCH:  return modelSscratch;
            CSR_ADDR_SEPC:      return modelSepc;
            CSR_ADDR_SCAUSE:    return {28'h0, modelScause};
            CSR_ADDR_STVAL:     return modelStval;
            CSR_ADDR_MSTATUS:   return modelStatus;
            CSR_ADDR_MISA:      return MISA_RV32I;
            CSR_ADDR_MEDELEG:   return modelMedeleg;
            CSR_ADDR_MTVEC:     return modelMtvec;
            CSR_ADDR_MSCRATCH:  return modelMscratch;
            CSR_ADDR_MEPC:      return modelMepc;
            CSR_ADDR_MCAUSE:    return {28'h0, modelMcause};
            CSR_ADDR_MTVAL:     return modelMtval;
            CSR_ADDR_CYCLE:     return modelCycles[31:0];
            CSR_ADDR_TIME:      return modelCycles[31:0];
            CSR_ADDR_CYCLEH:    return modelCycles[63:32];
            CSR_ADDR_TIMEH:     return modelCycles[63:32];
            CSR_ADDR_MHARTID:   return HART;
            default:            return '0;
        endcase
    endfunction

    function automatic word_t expectedNextPc();
        if (trap.valid) begin
            if (modelMedeleg[trap.cause]) begin
                return {modelStvec[31:2], 2'b00};
            end
            return {modelMtvec[31:2], 2'b00};
        end
        if (trapReturn && returnPrivilege == PrivMachine) begin
            return modelMepc;
        end
        if (trapReturn && returnPrivilege == PrivSupervisor) begin
            return modelSepc;
        end
        return '0;
    endfunction

    // ------------------------------
    // Stimulus and checks
    // ------------------------------
    task automatic driveRandomOp();
        word_t        pick;
        word_t        data;
        trapRequest_t nextTrap;
        csrWrite_t    nextWr;
        logic         nextReturn;
        privilege_e   nextRetPriv;
        logic [3:0]   sel;
        pick        = randomWord();
        data        = randomWord();
        nextTrap    = '0;
        nextWr      = '0;
        nextReturn  = 1'b0;
        nextRetPriv = pick[8] ? PrivSupervisor : PrivMachine;
        sel         = pick[7:4];
        if (sel > 4'd12) begin
            sel = sel - 4'd13;
        end
        case (pick[2:0])
            3'd2, 3'd3: begin
                nextWr.enable = 1'b1;
                nextWr.addr   = writeAddrFor(sel);
                // Keep mpp off the reserved encoding
                if (nextWr.addr == CSR_ADDR_MSTATUS && data[12:11] == 2'b10) begin
                    data[12] = 1'b0;
                end
                nextWr.data = data;
            end
            3'd4, 3'd5: begin
                nextTrap.valid = 1'b1;
                nextTrap.cause = data[3:0];
                nextTrap.pc    = randomWord();
                nextTrap.value = randomWord();
                nextReturn     = pick[9];
            end
            3'd6: begin
                nextReturn  = 1'b1;
                nextRetPriv = PrivMachine;
            end
            3'd7: begin
                nextReturn  = 1'b1;
                nextRetPriv = PrivSupervisor;
            end
            // Idle
            default: ;
        endcase
        trap            <= nextTrap;
        trapReturn      <= nextReturn;
        returnPrivilege <= nextRetPriv;
        csrWr           <= nextWr;
        readAddr        <= readAddrFor(pick[20:16], pick[31:20]);
    endtask

    task automatic checkOutputs();
        word_t expRead;
        word_t expPc;
        expRead    = expectedRead(readAddr);
        expPc      = expectedNextPc();
        checkCount = checkCount + 4;
        if (readValue !== expRead) begin
            errorCount++;
            $display("FAILED readValue (addr %h): got %h, expected %h", readAddr, readValue,
                     expRead);
        end
        if (nextPc !== expPc) begin
            errorCount++;
            $display("FAILED nextPc: got %h, expected %h", nextPc, expPc);
        end
        if (privilege !== privilege_e'(modelPriv)) begin
            errorCount++;
            $display("FAILED privilege: got %h, expected %h", privilege, modelPriv);
        end
        if (status !== csrStatus_t'(modelStatus)) begin
            errorCount++;
            $display("FAILED status: got %h, expected %h", status, modelStatus);
        end
    endtask

    initial begin
        trap            = '0;
        trapReturn      = 1'b0;
        returnPrivilege = PrivMachine;
        csrWr           = '0;
        readAddr        = '0;
        rngState        = 32'd63050;
        errorCount      = 0;
        checkCount      = 0;
        resetWait       = 0;
        resetModel();

        do begin
            @(negedge clk);
            resetWait++;
        end while (rst && resetWait < 10);

        if (rst !== 1'b0) begin
            $display("Reset was not released within 10 cycles");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            checkOutputs();

            for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
                @(posedge clk);
                updateModel();
                driveRandomOp();
                @(negedge clk);
                checkOutputs();
            end

            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

    // Watchdog on the whole run
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles, errors: %0d", TIMEOUT_CYCLES,
                 errorCount);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/csrTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module csrTopSva
    import csrPkg::*;
(
    input logic         clk,
    input logic         rst,
    input trapRequest_t trap,
    input logic         trapReturn,
    input csrWrite_t    csrWr,
    input privilege_e   privilege,
    input word_t        nextPc
);

    // Encoding 2'b10 is reserved
    privilegeLegal: assert property (@(posedge clk) disable iff (rst)
        privilege != privilege_e'(2'b10))
        else $error("privilege holds the reserved encoding");

    noWriteWithTrap: assert property (@(posedge clk) disable iff (rst)
        !(trap.valid && csrWr.enable))
        else $error("CSR write issued in the same cycle as a trap");

    idlePcZero: assert property (@(posedge clk) disable iff (rst)
        (!trap.valid && !trapReturn) |-> (nextPc == '0))
        else $error("nextPc is not zero in an idle cycle");

    machineAfterReset: assert property (@(posedge clk)
        rst |=> (privilege == PrivMachine))
        else $error("privilege is not machine after reset");

endmodule

bind csrTop csrTopSva u_sva (
    .clk        (clk),
    .rst        (rst),
    .trap       (trap),
    .trapReturn (trapReturn),
    .csrWr      (csrWr),
    .privilege  (privilege),
    .nextPc     (nextPc)
);

`default_nettype wire

//--- verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
